// File: design/audio_pkg.sv
package audio_pkg;

	// Width of one channel word on the serial line
	localparam int SAMPLE_WIDTH = 32;

	// Frame buffer depth, in stereo frames
	// Keep it a power of two so the pointers wrap on their own
	localparam int FIFO_DEPTH = 128;

	// Fill count has to reach FIFO_DEPTH itself
	localparam int FIFO_COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

	// Producer may write while the fill count is at or below this
	// Half the buffer, same as testing the top two bits of the free space
	localparam int ROOM_THRESHOLD = 64;

	// Flops on each codec clock pin before edge detection
	localparam int SYNC_STAGES = 2;

	// One channel sample, MSB goes out first
	typedef logic [SAMPLE_WIDTH-1:0] sample_t;

	// One stereo frame as stored in the buffer
	// Left sits in the upper half of the packed word
	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_frame_t;

endpackage

// File: design/i2s_edges_if.sv
`timescale 1ns/1ns

// Edge strobes of the codec clocks, each one clk wide
interface i2s_edges_if;

	// Bit clock edges
	logic bclk_rise;
	logic bclk_fall;

	// DAC left/right clock edges, silent until channels are aligned
	logic lrclk_rise;
	logic lrclk_fall;

	// Edge detector side
	modport tracker (
		output bclk_rise,
		output bclk_fall,
		output lrclk_rise,
		output lrclk_fall
	);

	// Shift register side
	modport serializer (
		input bclk_rise,
		input bclk_fall,
		input lrclk_rise,
		input lrclk_fall
	);

endinterface

// File: design/i2s_clock_tracker.sv
`timescale 1ns/1ns

module i2s_clock_tracker
	import audio_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         aud_bclk,
	input  logic         aud_daclrck,
	i2s_edges_if.tracker edges
);

	// Resync chains, pin enters at bit 0
	logic [SYNC_STAGES-1:0] bclk_sync;
	logic [SYNC_STAGES-1:0] lrclk_sync;

	// Last synchronized level, for edge compare
	logic bclk_prev;
	logic lrclk_prev;

	// Set once the first left/right falling edge has passed
	logic aligned;

	// Left/right edges before the alignment mask
	logic lrclk_rise_raw;
	logic lrclk_fall_raw;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bclk_sync  <= '0;
			lrclk_sync <= '0;
			bclk_prev  <= 1'b0;
			lrclk_prev <= 1'b0;
		end
		else
		begin
			bclk_sync  <= {bclk_sync[SYNC_STAGES-2:0], aud_bclk};
			lrclk_sync <= {lrclk_sync[SYNC_STAGES-2:0], aud_daclrck};
			bclk_prev  <= bclk_sync[SYNC_STAGES-1];
			lrclk_prev <= lrclk_sync[SYNC_STAGES-1];
		end
	end

	// Codec starts wherever it likes, so wait for a left/right fall
	// A left half-frame then always begins a fresh frame
	always_ff @(posedge clk)
	begin
		if (reset)
			aligned <= 1'b0;
		else if (lrclk_fall_raw)
			aligned <= 1'b1;
	end

	assign lrclk_rise_raw = lrclk_sync[SYNC_STAGES-1] & ~lrclk_prev;
	assign lrclk_fall_raw = ~lrclk_sync[SYNC_STAGES-1] & lrclk_prev;

	// Strobes, one clk wide, 2 to 3 clk after the pin moved
	assign edges.bclk_rise  = bclk_sync[SYNC_STAGES-1] & ~bclk_prev;
	assign edges.bclk_fall  = ~bclk_sync[SYNC_STAGES-1] & bclk_prev;
	assign edges.lrclk_rise = lrclk_rise_raw & aligned;
	assign edges.lrclk_fall = lrclk_fall_raw & aligned;

	// Codec moves the left/right clock only with a bit clock fall
	assert property (@(posedge clk) disable iff (reset)
		(edges.lrclk_rise || edges.lrclk_fall) |-> edges.bclk_fall);

endmodule

// File: design/frame_fifo.sv
`timescale 1ns/1ns

module frame_fifo
	import audio_pkg::*;
#(
	parameter int DEPTH = FIFO_DEPTH
)
(
	input  logic          clk,
	input  logic          reset,
	input  logic          push,
	input  stereo_frame_t push_frame,
	input  logic          pop,
	output stereo_frame_t head_frame,
	output logic          fifo_empty,
	output logic          sample_allowed
);

	localparam int PTR_WIDTH = $clog2(DEPTH);

	// Frame storage
	stereo_frame_t mem [DEPTH];

	// Circular pointers, wrap naturally at DEPTH
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;

	// Frames currently held
	logic [FIFO_COUNT_WIDTH-1:0] count;

	// Write that actually lands in the buffer
	logic push_ok;

	// Writes while the room flag is low are dropped here
	assign push_ok = push & sample_allowed;

	always_ff @(posedge clk)
	begin
		if (push_ok)
			mem[wr_ptr] <= push_frame;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Fill count, unchanged on simultaneous push and pop
	always_ff @(posedge clk)
	begin
		if (reset)
			count <= '0;
		else
		begin
			case ({push_ok, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Room flag lags the count by one clk
	// Low right after reset, up on the next cycle
	always_ff @(posedge clk)
	begin
		if (reset)
			sample_allowed <= 1'b0;
		else
			sample_allowed <= (count <= ROOM_THRESHOLD);
	end

	// Show-ahead, oldest frame always on the output
	assign head_frame = mem[rd_ptr];
	assign fifo_empty = (count == '0);

	// Room flag keeps the buffer well away from full
	assert property (@(posedge clk) disable iff (reset) count <= DEPTH);

	// Serializer only pops what is there
	assert property (@(posedge clk) disable iff (reset) pop |-> !fifo_empty);

endmodule

// File: design/dac_serializer.sv
`timescale 1ns/1ns

module dac_serializer
	import audio_pkg::*;
(
	input  logic            clk,
	input  logic            reset,
	i2s_edges_if.serializer edges,
	input  stereo_frame_t   head_frame,
	input  logic            fifo_empty,
	output logic            pop,
	output logic            aud_dacdat
);

	// Outgoing word, MSB on the line
	sample_t shift_reg;

	// Right word parked for the second half-frame
	sample_t right_hold;

	// A left word went out in this frame
	logic left_sent;

	// Load conditions for each half-frame
	logic load_left;
	logic load_right;

	// Left half starts with lrclk rising, only if a frame is waiting
	assign load_left  = edges.lrclk_rise & ~fifo_empty;
	assign load_right = edges.lrclk_fall & left_sent;

	// Frame leaves the buffer as its left half starts
	assign pop = load_left;

	always_ff @(posedge clk)
	begin
		if (load_left)
			right_hold <= head_frame.right;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			left_sent <= 1'b0;
		else if (edges.lrclk_rise)
			left_sent <= ~fifo_empty;
		else if (edges.lrclk_fall)
			left_sent <= 1'b0;
	end

	// Loads win over shifting
	// Lrclk and bclk fall strobes arrive together at a half-frame start
	always_ff @(posedge clk)
	begin
		if (reset)
			shift_reg <= '0;
		else if (load_left)
			shift_reg <= head_frame.left;
		else if (load_right)
			shift_reg <= right_hold;
		else if (edges.lrclk_rise | edges.lrclk_fall)
			// Underflow, send silence for this half
			shift_reg <= '0;
		else if (edges.bclk_fall)
			shift_reg <= {shift_reg[SAMPLE_WIDTH-2:0], 1'b0};
	end

	// Registered pin, one clk behind the shift register
	always_ff @(posedge clk)
	begin
		if (reset)
			aud_dacdat <= 1'b0;
		else
			aud_dacdat <= shift_reg[SAMPLE_WIDTH-1];
	end

endmodule

// File: design/audio_dac_out.sv
`timescale 1ns/1ns

module audio_dac_out
	import audio_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  sample_t left_sample,
	input  sample_t right_sample,
	input  logic    write_sample,
	output logic    sample_allowed,
	input  logic    aud_bclk,
	input  logic    aud_daclrck,
	output logic    aud_dacdat
);

	// Both channels travel as one frame
	stereo_frame_t write_frame;

	// FIFO head and handshake to the serializer
	stereo_frame_t head_frame;
	logic          fifo_empty;
	logic          pop;

	// Codec clock edge strobes
	i2s_edges_if edges ();

	assign write_frame.left  = left_sample;
	assign write_frame.right = right_sample;

	i2s_clock_tracker u_i2s_clock_tracker (
		.clk         (clk),
		.reset       (reset),
		.aud_bclk    (aud_bclk),
		.aud_daclrck (aud_daclrck),
		.edges       (edges)
	);

	// Drop-on-full write port, room flag goes straight out
	frame_fifo #(
		.DEPTH (FIFO_DEPTH)
	) u_frame_fifo (
		.clk            (clk),
		.reset          (reset),
		.push           (write_sample),
		.push_frame     (write_frame),
		.pop            (pop),
		.head_frame     (head_frame),
		.fifo_empty     (fifo_empty),
		.sample_allowed (sample_allowed)
	);

	dac_serializer u_dac_serializer (
		.clk        (clk),
		.reset      (reset),
		.edges      (edges),
		.head_frame (head_frame),
		.fifo_empty (fifo_empty),
		.pop        (pop),
		.aud_dacdat (aud_dacdat)
	);

endmodule

// File: sim/codec_clock_gen.sv
`timescale 1ns/1ns

// Codec model as clock master
// Bit clock toggles every HALF_CLKS clk cycles
// Left/right clock toggles on a bit clock fall, once per 32 bit periods
module codec_clock_gen
#(
	parameter int HALF_CLKS = 5
)
(
	input  logic clk,
	input  logic reset,
	output logic aud_bclk,
	output logic aud_daclrck
);

	// clk cycles since the last bit clock toggle
	int div_cnt;

	// Bit clock falls within the current half-frame
	int bit_cnt;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			div_cnt     <= 0;
			bit_cnt     <= 0;
			aud_bclk    <= 1'b0;
			aud_daclrck <= 1'b0;
		end
		else if (div_cnt == HALF_CLKS - 1)
		begin
			div_cnt  <= 0;
			aud_bclk <= ~aud_bclk;
			// High now, so this toggle is a falling edge
			if (aud_bclk)
			begin
				if (bit_cnt == 31)
				begin
					bit_cnt     <= 0;
					// Half-frame boundary, same instant as the bclk fall
					aud_daclrck <= ~aud_daclrck;
				end
				else
					bit_cnt <= bit_cnt + 1;
			end
		end
		else
			div_cnt <= div_cnt + 1;
	end

endmodule

// File: sim/tb_audio_dac_out.sv
`timescale 1ns/1ns

module tb_audio_dac_out
	import audio_pkg::*;
;

	localparam int CLK_PERIOD_NS = 20;
	localparam int BCLK_HALF_CLKS = 5;
	localparam int BCLK_PERIOD_NS = 2 * BCLK_HALF_CLKS * CLK_PERIOD_NS;
	// Rough frame count of all tests, with headroom
	localparam int FRAME_BUDGET = 160;
	localparam int WATCHDOG_NS = FRAME_BUDGET * 64 * BCLK_PERIOD_NS + 50000;
	localparam int BURST_LEN = 100;

	logic    clk;
	logic    reset;
	logic    codec_reset;
	sample_t left_sample;
	sample_t right_sample;
	logic    write_sample;
	logic    sample_allowed;
	logic    aud_bclk;
	logic    aud_daclrck;
	logic    aud_dacdat;

	// Reference model, accepted frames and frames due on the line
	stereo_frame_t acc_q[$];
	stereo_frame_t exp_q[$];
	stereo_frame_t new_frame;

	// clk edges left until the DUT pop decision
	int pop_wait;
	// Model view of the channel alignment
	logic tb_aligned;
	logic lr_prev;
	logic bclk_prev;
	logic lr_at_rise;
	int lr_rises;

	// Serial word assembly, -1 means no valid word in progress
	int bit_cnt;
	sample_t word;
	logic have_left;
	int frames_checked;

	logic saw_low;
	int burst_accepted;

	audio_dac_out u_audio_dac_out (
		.clk            (clk),
		.reset          (reset),
		.left_sample    (left_sample),
		.right_sample   (right_sample),
		.write_sample   (write_sample),
		.sample_allowed (sample_allowed),
		.aud_bclk       (aud_bclk),
		.aud_daclrck    (aud_daclrck),
		.aud_dacdat     (aud_dacdat)
	);

	codec_clock_gen #(
		.HALF_CLKS (BCLK_HALF_CLKS)
	) u_codec_clock_gen (
		.clk         (clk),
		.reset       (codec_reset),
		.aud_bclk    (aud_bclk),
		.aud_daclrck (aud_daclrck)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD_NS / 2) clk = ~clk;
	end

	// Stops a stuck run
	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the tests did not finish in the expected time");
		$display("TEST FAIL");
		$fatal(1);
	end

	task automatic report_mismatch(input string msg);
		$display("MISMATCH at %0t: %s", $time, msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	// One finished 32-bit word from the line
	task automatic compare_word(input logic is_left, input sample_t got);
		if (is_left)
		begin
			have_left = (exp_q.size() > 0);
			if (have_left)
				assert (got == exp_q[0].left)
				else report_mismatch($sformatf("left word %h, expected %h", got, exp_q[0].left));
		end
		else if (have_left && exp_q.size() > 0)
		begin
			assert (got == exp_q[0].right)
			else report_mismatch($sformatf("right word %h, expected %h", got, exp_q[0].right));
			void'(exp_q.pop_front());
			frames_checked++;
			have_left = 1'b0;
		end
	endtask

	// Model and monitor, all on the pre-edge values
	always @(posedge clk)
	begin
		if (reset)
		begin
			acc_q.delete();
			exp_q.delete();
			pop_wait = 0;
			tb_aligned = 1'b0;
			bit_cnt = -1;
			have_left = 1'b0;
		end
		else
		begin
			// DUT pops two edges after the pin rise is first seen here
			if (pop_wait > 0)
			begin
				pop_wait--;
				if (pop_wait == 0)
				begin
					if (acc_q.size() > 0)
						exp_q.push_back(acc_q.pop_front());
					else
						exp_q.push_back('0);
				end
			end
			if (aud_daclrck && !lr_prev)
			begin
				lr_rises++;
				if (tb_aligned)
					pop_wait = 2;
			end
			if (!aud_daclrck && lr_prev)
				tb_aligned = 1'b1;
			// Accepted write, counted after the pop decision of this edge
			if (write_sample && sample_allowed)
			begin
				new_frame.left = left_sample;
				new_frame.right = right_sample;
				acc_q.push_back(new_frame);
			end
			// Data sampled at the bit clock rise
			if (aud_bclk && !bclk_prev)
			begin
				if (aud_daclrck != lr_at_rise)
				begin
					bit_cnt = 0;
					word = '0;
				end
				lr_at_rise = aud_daclrck;
				if (bit_cnt >= 0 && bit_cnt < SAMPLE_WIDTH)
				begin
					word = {word[SAMPLE_WIDTH-2:0], aud_dacdat};
					bit_cnt++;
					if (bit_cnt == SAMPLE_WIDTH)
						compare_word(aud_daclrck, word);
				end
			end
		end
		lr_prev = aud_daclrck;
		bclk_prev = aud_bclk;
	end

	// Line idle and room flag still low as reset drops
	assert property (@(posedge clk) $fell(reset) |-> !aud_dacdat && !sample_allowed)
	else report_mismatch("line or room flag not idle right after reset");

	// Room flag up one cycle later
	assert property (@(posedge clk) $fell(reset) |=> sample_allowed)
	else report_mismatch("room flag did not rise after reset");

	// Silent line until the channels are aligned
	assert property (@(posedge clk) disable iff (reset) !tb_aligned |-> !aud_dacdat)
	else report_mismatch("data on the line before channel alignment");

	task automatic apply_reset();
		@(posedge clk);
		reset <= 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
	endtask

	// Single write, then a few idle cycles
	task automatic write_one(input int gap);
		while (!sample_allowed)
			@(posedge clk);
		@(posedge clk);
		write_sample <= 1'b1;
		left_sample <= $urandom();
		right_sample <= $urandom();
		@(posedge clk);
		write_sample <= 1'b0;
		repeat (gap) @(posedge clk);
	endtask

	task automatic write_burst(input int len);
		saw_low = 1'b0;
		burst_accepted = 0;
		repeat (len)
		begin
			@(posedge clk);
			if (write_sample && sample_allowed)
				burst_accepted++;
			if (!sample_allowed)
				saw_low = 1'b1;
			write_sample <= 1'b1;
			left_sample <= $urandom();
			right_sample <= $urandom();
		end
		@(posedge clk);
		if (write_sample && sample_allowed)
			burst_accepted++;
		write_sample <= 1'b0;
	endtask

	task automatic wait_frames(input int n);
		int target;
		target = frames_checked + n;
		while (frames_checked < target)
			@(posedge clk);
	endtask

	task automatic wait_drained();
		while (acc_q.size() > 0 || exp_q.size() > 0 || have_left)
			@(posedge clk);
	endtask

	initial
	begin
		void'($urandom(32'h926b64b9));
		reset = 1'b1;
		codec_reset = 1'b1;
		write_sample = 1'b0;
		left_sample = '0;
		right_sample = '0;
		frames_checked = 0;
		lr_rises = 0;
		lr_at_rise = 1'b0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		codec_reset <= 1'b0;

		// Two frames wait in the buffer across the unaligned first lrclk rise
		repeat (2) write_one(2);

		// Those two, then nothing written, frames decode as zero
		wait_frames(5);

		// Slow writes, order and bit order
		repeat (6) write_one(200);
		wait_drained();

		// Burst against the room flag
		write_burst(BURST_LEN);
		assert (saw_low && burst_accepted < BURST_LEN)
		else report_mismatch("burst never drove the room flag low");
		wait_drained();

		// Reset with frames still queued
		repeat (5) write_one(2);
		begin
			int rises;
			rises = lr_rises;
			while (lr_rises == rises)
				@(posedge clk);
		end
		repeat (20) @(posedge clk);
		assert (acc_q.size() > 0)
		else report_mismatch("no frames queued before the mid-stream reset");
		apply_reset();
		wait_frames(3);
		repeat (3) write_one(50);
		wait_drained();

		$display("TEST PASS");
		$finish;
	end

endmodule

// File: sources.f
design/audio_pkg.sv
design/i2s_edges_if.sv
design/i2s_clock_tracker.sv
design/frame_fifo.sv
design/dac_serializer.sv
design/audio_dac_out.sv
sim/codec_clock_gen.sv
sim/tb_audio_dac_out.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the pass line shows up

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_audio_dac_out -f sources.f \
	&& ./obj_dir/Vtb_audio_dac_out | tee /dev/stderr | grep -qx "TEST PASS" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
